/* memAccess.f */
+incdir+common
common/lsOpPkg.sv
common/memTypesPkg.sv
src/handshakeFifo.sv
loadStore/loadStoreUnit.sv
loadStore/fixedMemory.sv
src/memWritebackArbiter.sv
src/memAccessTop.sv
verif/memAccessChecker.sv
verif/memAccessTb.sv

/* run.sh */
#!/bin/sh
# Build and run the memory access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f memAccess.f --top-module memAccessTb \
    -o memAccessSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memAccessSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

/* verif/memAccessTb.sv */
`timescale 1ns/1ns
`include "memAccess_defines.svh"

module memAccessTb;
    import memTypesPkg::*;
    import lsOpPkg::*;

    localparam int flashWords = `FIXED_MEM_WORDS;
    localparam int totalRequests = 32 + 48 + 32 + 48 + 48 + 16;
    localparam int cycleLimit = flashWords + totalRequests * 40;

    logic                         clk;
    logic                         rstN;
    logic                         flashEn;
    logic [`FLASH_ADDR_WIDTH-1:0] flashAddr;
    dataWord_t                    flashData;
    logic                         lsReq;
    logic                         lsAck;
    lsRequest_t                   lsReqData;
    logic                         ioOutReq;
    logic                         ioOutAck;
    lsRequest_t                   ioOut;
    logic                         ioInReq;
    logic                         ioInAck;
    wbResult_t                    ioIn;
    logic                         regWriteEn;
    wbResult_t                    regWrite;
    int                           errorCount;
    int                           outstanding;

    integer    seed;
    int        cycles;
    int        testsRun;
    int        testsFailed;
    logic      slowIo;
    wbResult_t ioReturns [$];

    memAccessTop i_memAccessTop (.*);

    memAccessChecker resultCheck (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int randBelow(input int bound);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % bound;
    endfunction

    task automatic sendRequest(input lsRequest_t req);
        lsReqData = req;
        lsReq     = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!lsAck);
        lsReq = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (lsAck);
    endtask

    // Open loads and IO requests must all close, then a quiet spell
    // gives stray writes a chance to show up
    task automatic waitDrained();
        do begin
            @(posedge clk);
            #1;
        end while (outstanding != 0);
        repeat (20) @(posedge clk);
        #1;
    endtask

    task automatic flashMemory();
        for (int a = 0; a < flashWords; a++) begin
            flashEn   = 1'b1;
            flashAddr = `FLASH_ADDR_WIDTH'(a);
            flashData = 16'($random(seed));
            @(posedge clk);
            #1;
        end
        flashEn = 1'b0;
    endtask

    // addrMode 0 small fixed range, 1 whole fixed window, 2 IO only, 3 mixed
    // opMode 0 loads, 1 loads and stores, 2 no-op codes
    task automatic runTest(input string name, input int count, input int addrMode,
                           input int opMode);
        lsRequest_t req;
        int         errorsBefore;
        int         loads;
        errorsBefore = errorCount;
        resultCheck.testName = name;
        loads = 0;
        for (int i = 0; i < count; i++) begin
            case (opMode)
                0:       req.opcode = LS_LOAD;
                1:       req.opcode = (randBelow(2) == 1) ? LS_STORE : LS_LOAD;
                default: req.opcode = lsOpcode_t'(4'(2 + randBelow(14)));
            endcase
            case (addrMode)
                0:       req.address = 16'(randBelow(32));
                1:       req.address = 16'(randBelow(flashWords));
                2:       req.address = 16'(flashWords + randBelow(65536 - flashWords));
                default: req.address = (randBelow(2) == 1) ? 16'(randBelow(flashWords))
                                     : 16'(flashWords + randBelow(65536 - flashWords));
            endcase
            req.storeValue = 16'($random(seed));
            req.destReg    = 4'(randBelow(16));
            // Unique destination per batch of loads in flight
            if (req.opcode == LS_LOAD) begin
                if (loads == 16) begin
                    waitDrained();
                    loads = 0;
                end
                req.destReg = 4'(loads);
                loads++;
            end
            sendRequest(req);
        end
        waitDrained();
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("%s: done, no errors", name);
        end else begin
            testsFailed++;
            $display("%s: done, %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // IO device, outbound side acks after a random wait
    initial begin
        int        waitLeft;
        wbResult_t reply;
        waitLeft = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ioOutAck) begin
                if (!ioOutReq) begin
                    ioOutAck = 1'b0;
                end
            end else if (ioOutReq) begin
                if (waitLeft > 0) begin
                    waitLeft--;
                end else begin
                    ioOutAck = 1'b1;
                    if (ioOut.opcode == LS_LOAD) begin
                        reply.destReg = ioOut.destReg;
                        reply.data    = 16'($random(seed));
                        ioReturns.push_back(reply);
                    end
                    waitLeft = slowIo ? randBelow(32) : randBelow(4);
                end
            end
        end
    end

    // IO device, inbound side returns load data later
    initial begin
        int returnWait;
        returnWait = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ioInReq) begin
                if (ioInAck) begin
                    ioInReq = 1'b0;
                end
            end else if (!ioInAck && (ioReturns.size() > 0)) begin
                if (returnWait > 0) begin
                    returnWait--;
                end else begin
                    ioIn       = ioReturns.pop_front();
                    ioInReq    = 1'b1;
                    returnWait = randBelow(8);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, requests did not complete", cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed        = 1;
        testsRun    = 0;
        testsFailed = 0;
        slowIo      = 1'b0;
        rstN        = 1'b0;
        flashEn     = 1'b0;
        flashAddr   = '0;
        flashData   = '0;
        lsReq       = 1'b0;
        lsReqData   = '0;
        ioOutAck    = 1'b0;
        ioInReq     = 1'b0;
        ioIn        = '0;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;

        flashMemory();
        runTest("flash preload", 32, 1, 0);
        runTest("fixed store load", 48, 0, 1);
        runTest("io window", 32, 2, 1);
        runTest("io and fixed", 48, 3, 0);
        slowIo = 1'b1;
        runTest("back pressure", 48, 3, 1);
        slowIo = 1'b0;
        runTest("noop drop", 16, 3, 2);

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if ((testsFailed == 0) && (errorCount == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verif/memAccessChecker.sv */
`timescale 1ns/1ns
`include "memAccess_defines.svh"

module memAccessChecker (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          flashEn,
    input  logic [`FLASH_ADDR_WIDTH-1:0]  flashAddr,
    input  memTypesPkg::dataWord_t        flashData,
    input  logic                          lsAck,
    input  memTypesPkg::lsRequest_t       lsReqData,
    input  logic                          ioOutReq,
    input  memTypesPkg::lsRequest_t       ioOut,
    input  logic                          ioInAck,
    input  memTypesPkg::wbResult_t        ioIn,
    input  logic                          regWriteEn,
    input  memTypesPkg::wbResult_t        regWrite,
    output int                            errorCount,
    output int                            outstanding
);
    import memTypesPkg::*;
    import lsOpPkg::*;

    localparam int regCount = 2 ** `REG_ADDR_WIDTH;

    string      testName = "reset";
    dataWord_t  memModel [`FIXED_MEM_WORDS];
    dataWord_t  expData [regCount];
    logic       loadPending [regCount];
    logic       dataKnown [regCount];
    lsRequest_t ioExpected [$];
    int         pendingLoads;
    logic       lastLsAck;
    logic       lastIoOutReq;
    logic       lastIoInAck;

    // Sampled on the falling edge, halfway between DUT updates and stimulus
    always @(negedge clk or negedge rstN) begin
        lsRequest_t req;
        regAddr_t   dest;
        if (!rstN) begin
            errorCount   = 0;
            pendingLoads = 0;
            lastLsAck    = 1'b0;
            lastIoOutReq = 1'b0;
            lastIoInAck  = 1'b0;
            ioExpected.delete();
            for (int r = 0; r < regCount; r++) begin
                loadPending[r] = 1'b0;
                dataKnown[r]   = 1'b0;
            end
        end else begin
            if (flashEn) begin
                memModel[flashAddr] = flashData;
            end

            // Accepted request, the FIFO keeps the order so the model can act now
            if (lsAck && !lastLsAck) begin
                req  = lsReqData;
                dest = req.destReg;
                if ((req.opcode == LS_LOAD) || (req.opcode == LS_STORE)) begin
                    if (req.address >= `FIXED_MEM_WORDS) begin
                        ioExpected.push_back(req);
                    end else if (req.opcode == LS_STORE) begin
                        memModel[req.address[`FLASH_ADDR_WIDTH-1:0]] = req.storeValue;
                    end
                    if (req.opcode == LS_LOAD) begin
                        loadPending[dest] = 1'b1;
                        dataKnown[dest]   = (req.address < `FIXED_MEM_WORDS);
                        expData[dest]     = memModel[req.address[`FLASH_ADDR_WIDTH-1:0]];
                        pendingLoads++;
                    end
                end
            end

            if (ioOutReq && !lastIoOutReq) begin
                if (ioExpected.size() == 0) begin
                    $display("%s: request appeared on ioOut that was never sent there",
                        testName);
                    errorCount++;
                end else begin
                    req = ioExpected.pop_front();
                    if (ioOut !== req) begin
                        $display("ERR %s ioOut expected %h actual %h", testName, req, ioOut);
                        errorCount++;
                    end
                end
            end

            // IO device answer fixes the data of a pending IO load
            if (ioInAck && !lastIoInAck) begin
                dest = ioIn.destReg;
                if (!loadPending[dest] || dataKnown[dest]) begin
                    $display("%s: ioIn result for r%0d without an open IO load", testName, dest);
                    errorCount++;
                end else begin
                    expData[dest]   = ioIn.data;
                    dataKnown[dest] = 1'b1;
                end
            end

            if (regWriteEn) begin
                dest = regWrite.destReg;
                if (!loadPending[dest] || !dataKnown[dest]) begin
                    $display("%s: register write to r%0d with no load waiting", testName, dest);
                    errorCount++;
                end else begin
                    if (regWrite.data !== expData[dest]) begin
                        $display("ERR %s r%0d expected %h actual %h", testName, dest,
                            expData[dest], regWrite.data);
                        errorCount++;
                    end
                    loadPending[dest] = 1'b0;
                    pendingLoads--;
                end
            end

            lastLsAck    = lsAck;
            lastIoOutReq = ioOutReq;
            lastIoInAck  = ioInAck;
        end
        outstanding = pendingLoads + ioExpected.size();
    end

endmodule

/* src/memAccessTop.sv */
`timescale 1ns/1ns
`include "memAccess_defines.svh"

module memAccessTop (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          flashEn,
    input  logic [`FLASH_ADDR_WIDTH-1:0]  flashAddr,
    input  memTypesPkg::dataWord_t        flashData,
    input  logic                          lsReq,
    output logic                          lsAck,
    input  memTypesPkg::lsRequest_t       lsReqData,
    output logic                          ioOutReq,
    input  logic                          ioOutAck,
    output memTypesPkg::lsRequest_t       ioOut,
    input  logic                          ioInReq,
    output logic                          ioInAck,
    input  memTypesPkg::wbResult_t        ioIn,
    output logic                          regWriteEn,
    output memTypesPkg::wbResult_t        regWrite
);
    import memTypesPkg::*;

    logic       fifoOutReq;
    logic       fifoOutAck;
    lsRequest_t fifoOut;
    logic       memReq;
    logic       memAck;
    lsRequest_t memIn;
    logic       retReq;
    logic       retAck;
    wbResult_t  ret;
    logic       fixedRetReq;
    logic       fixedRetAck;
    wbResult_t  fixedRet;

    handshakeFifo #(.payload_t(lsRequest_t)) requestFifo (
        .clk(clk), .rstN(rstN),
        .inReq(lsReq), .inAck(lsAck), .inData(lsReqData),
        .outReq(fifoOutReq), .outAck(fifoOutAck), .outData(fifoOut)
    );

    loadStoreUnit lsUnit (
        .clk(clk), .rstN(rstN),
        .fifoOutReq(fifoOutReq), .fifoOutAck(fifoOutAck), .fifoOut(fifoOut),
        .memReq(memReq), .memAck(memAck), .memOut(memIn),
        .ioOutReq(ioOutReq), .ioOutAck(ioOutAck), .ioOut(ioOut)
    );

    fixedMemory fixedMem (
        .clk(clk), .rstN(rstN),
        .flashEn(flashEn), .flashAddr(flashAddr), .flashData(flashData),
        .memReq(memReq), .memAck(memAck), .memIn(memIn),
        .retReq(retReq), .retAck(retAck), .ret(ret)
    );

    handshakeFifo #(.payload_t(wbResult_t)) returnFifo (
        .clk(clk), .rstN(rstN),
        .inReq(retReq), .inAck(retAck), .inData(ret),
        .outReq(fixedRetReq), .outAck(fixedRetAck), .outData(fixedRet)
    );

    memWritebackArbiter wbArbiter (
        .clk(clk), .rstN(rstN),
        .fixedRetReq(fixedRetReq), .fixedRetAck(fixedRetAck), .fixedRet(fixedRet),
        .ioInReq(ioInReq), .ioInAck(ioInAck), .ioIn(ioIn),
        .regWriteEn(regWriteEn), .regWrite(regWrite)
    );

endmodule

/* src/memWritebackArbiter.sv */
`timescale 1ns/1ns

module memWritebackArbiter (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   fixedRetReq,
    output logic                   fixedRetAck,
    input  memTypesPkg::wbResult_t fixedRet,
    input  logic                   ioInReq,
    output logic                   ioInAck,
    input  memTypesPkg::wbResult_t ioIn,
    output logic                   regWriteEn,
    output memTypesPkg::wbResult_t regWrite
);
    import memTypesPkg::*;

    logic idle;
    logic grantFixed;
    logic grantIo;
    logic writePending;

    // One handshake at a time, both acks must be released first
    assign idle = !fixedRetAck && !ioInAck;
    // Fixed memory wins when both sources are waiting
    assign grantFixed = idle && fixedRetReq;
    assign grantIo = idle && !fixedRetReq && ioInReq;

    always_ff @(posedge clk) begin
        if (grantFixed) begin
            regWrite <= fixedRet;
        end else if (grantIo) begin
            regWrite <= ioIn;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fixedRetAck  <= 1'b0;
            ioInAck      <= 1'b0;
            writePending <= 1'b0;
            regWriteEn   <= 1'b0;
        end else begin
            if (grantFixed) begin
                fixedRetAck <= 1'b1;
            end else if (fixedRetAck && !fixedRetReq) begin
                fixedRetAck <= 1'b0;
            end

            if (grantIo) begin
                ioInAck <= 1'b1;
            end else if (ioInAck && !ioInReq) begin
                ioInAck <= 1'b0;
            end

            // Register write follows the winning ack by one cycle
            writePending <= grantFixed || grantIo;
            regWriteEn   <= writePending;
        end
    end

    singleGrant: assert property (@(posedge clk) disable iff (!rstN)
        !(fixedRetAck && ioInAck))
        else $error("arbiter acked both sources");

endmodule

/* loadStore/fixedMemory.sv */
`timescale 1ns/1ns
`include "memAccess_defines.svh"

module fixedMemory (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          flashEn,
    input  logic [`FLASH_ADDR_WIDTH-1:0]  flashAddr,
    input  memTypesPkg::dataWord_t        flashData,
    input  logic                          memReq,
    output logic                          memAck,
    input  memTypesPkg::lsRequest_t       memIn,
    output logic                          retReq,
    input  logic                          retAck,
    output memTypesPkg::wbResult_t        ret
);
    import memTypesPkg::*;
    import lsOpPkg::*;

    localparam int addrWidth = $clog2(`FIXED_MEM_WORDS);

    dataWord_t            words [`FIXED_MEM_WORDS];
    logic [addrWidth-1:0] wordAddr;
    logic                 newReq;
    logic                 isLoad;
    logic                 accept;
    logic                 doLoad;
    logic                 resultPending;

    // Window check upstream keeps the upper address bits at zero
    assign wordAddr = memIn.address[addrWidth-1:0];
    assign newReq = memReq && !memAck;
    assign isLoad = (memIn.opcode == LS_LOAD);
    // A load waits while the previous result is still unclaimed
    assign accept = newReq && (!isLoad || !resultPending);
    assign doLoad = accept && isLoad;

    always_ff @(posedge clk) begin
        if (flashEn) begin
            words[flashAddr] <= flashData;
        end else if (accept && (memIn.opcode == LS_STORE)) begin
            words[wordAddr] <= memIn.storeValue;
        end
        if (doLoad) begin
            ret.destReg <= memIn.destReg;
            ret.data    <= words[wordAddr];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memAck        <= 1'b0;
            retReq        <= 1'b0;
            resultPending <= 1'b0;
        end else begin
            if (accept) begin
                memAck <= 1'b1;
            end else if (memAck && !memReq) begin
                memAck <= 1'b0;
            end

            if (retReq && retAck) begin
                retReq        <= 1'b0;
                resultPending <= 1'b0;
            end else begin
                if (doLoad) begin
                    resultPending <= 1'b1;
                end
                // Result goes out once the return FIFO has released its ack
                if (resultPending && !retReq && !retAck) begin
                    retReq <= 1'b1;
                end
            end
        end
    end

    retHeldStable: assert property (@(posedge clk) disable iff (!rstN)
        (retReq && !retAck) |=> (retReq && $stable(ret)))
        else $error("fixedMemory result changed before retAck");

endmodule

/* loadStore/loadStoreUnit.sv */
`timescale 1ns/1ns

module loadStoreUnit (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    fifoOutReq,
    output logic                    fifoOutAck,
    input  memTypesPkg::lsRequest_t fifoOut,
    output logic                    memReq,
    input  logic                    memAck,
    output memTypesPkg::lsRequest_t memOut,
    output logic                    ioOutReq,
    input  logic                    ioOutAck,
    output memTypesPkg::lsRequest_t ioOut
);
    import memTypesPkg::*;
    import lsOpPkg::*;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_ROUTE,
        LSU_WAIT_ACK,
        LSU_RELEASE
    } lsuState_t;

    lsuState_t  state;
    lsRequest_t current;
    logic       isMemOp;

    assign isMemOp = (current.opcode == LS_LOAD) || (current.opcode == LS_STORE);

    // Held request drives both targets, only one req line is raised
    assign memOut = current;
    assign ioOut = current;

    always_ff @(posedge clk) begin
        if ((state == LSU_IDLE) && fifoOutReq && !fifoOutAck) begin
            current <= fifoOut;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= LSU_IDLE;
            fifoOutAck <= 1'b0;
            memReq     <= 1'b0;
            ioOutReq   <= 1'b0;
        end else begin
            // FIFO side closes its handshake independently of routing
            if ((state == LSU_IDLE) && fifoOutReq && !fifoOutAck) begin
                fifoOutAck <= 1'b1;
            end else if (fifoOutAck && !fifoOutReq) begin
                fifoOutAck <= 1'b0;
            end

            case (state)
                LSU_IDLE: begin
                    if (fifoOutReq && !fifoOutAck) begin
                        state <= LSU_ROUTE;
                    end
                end
                LSU_ROUTE: begin
                    if (!isMemOp) begin
                        state <= LSU_IDLE;
                    end else if (isFixedAddress(current.address)) begin
                        memReq <= 1'b1;
                        state  <= LSU_WAIT_ACK;
                    end else begin
                        ioOutReq <= 1'b1;
                        state    <= LSU_WAIT_ACK;
                    end
                end
                LSU_WAIT_ACK: begin
                    if ((memReq && memAck) || (ioOutReq && ioOutAck)) begin
                        memReq   <= 1'b0;
                        ioOutReq <= 1'b0;
                        state    <= LSU_RELEASE;
                    end
                end
                LSU_RELEASE: begin
                    // Target must drop its ack before the next request
                    if (!memAck && !ioOutAck) begin
                        state <= LSU_IDLE;
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    oneTarget: assert property (@(posedge clk) disable iff (!rstN)
        !(memReq && ioOutReq))
        else $error("loadStoreUnit drove both targets");

    memReqHeld: assert property (@(posedge clk) disable iff (!rstN)
        (memReq && !memAck) |=> memReq)
        else $error("memReq fell before memAck");

    ioReqHeld: assert property (@(posedge clk) disable iff (!rstN)
        (ioOutReq && !ioOutAck) |=> ioOutReq)
        else $error("ioOutReq fell before ioOutAck");

endmodule

/* src/handshakeFifo.sv */
`timescale 1ns/1ns
`include "memAccess_defines.svh"

module handshakeFifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     inReq,
    output logic     inAck,
    input  payload_t inData,
    output logic     outReq,
    input  logic     outAck,
    output payload_t outData
);
    localparam int depth = `FIFO_DEPTH;
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int countWidth = $clog2(depth + 1);

    payload_t              entries [depth];
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [countWidth-1:0] count;
    logic                  full;
    logic                  push;
    logic                  pop;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == countWidth'(depth));
    // New entry only after the previous ack has been released
    assign push = inReq && !inAck && !full;
    // Head entry leaves once the sink has answered
    assign pop = outReq && outAck;
    assign outData = entries[rdPtr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            inAck  <= 1'b0;
            outReq <= 1'b0;
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                inAck <= 1'b1;
                wrPtr <= nextPtr(wrPtr);
            end else if (inAck && !inReq) begin
                inAck <= 1'b0;
            end

            if (pop) begin
                outReq <= 1'b0;
                rdPtr  <= nextPtr(rdPtr);
            end else if (!outReq && !outAck && (count != '0)) begin
                outReq <= 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= inData;
        end
    end

    // A write never lands on the unread head entry
    noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        (push && (count != '0)) |-> (wrPtr != rdPtr))
        else $error("handshakeFifo wrote while full");

endmodule

/* common/memTypesPkg.sv */
`include "memAccess_defines.svh"

package memTypesPkg;

    typedef logic [`DATA_WIDTH-1:0] dataWord_t;

    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

    // One load or store as issued to the memory side
    typedef struct packed {
        lsOpPkg::lsOpcode_t opcode;
        dataWord_t          address;
        dataWord_t          storeValue;
        regAddr_t           destReg;
    } lsRequest_t;

    // Load result on its way to the register write port
    typedef struct packed {
        regAddr_t  destReg;
        dataWord_t data;
    } wbResult_t;

endpackage

/* common/lsOpPkg.sv */
`include "memAccess_defines.svh"

package lsOpPkg;

    // Minor opcodes of the load/store path
    // Any other code is carried through the FIFO and dropped as a no-op
    typedef enum logic [3:0] {
        LS_LOAD  = 4'h0,
        LS_STORE = 4'h1
    } lsOpcode_t;

    // Addresses below the window bound live in the on-chip data memory,
    // everything above goes out through the IO port
    function automatic logic isFixedAddress(input logic [`DATA_WIDTH-1:0] address);
        logic inWindow;
        inWindow = (address < `FIXED_MEM_WORDS);
        return inWindow;
    endfunction

endpackage

/* common/memAccess_defines.svh */
`ifndef MEM_ACCESS_DEFINES_SVH
`define MEM_ACCESS_DEFINES_SVH

// Width of data words and memory addresses
`define DATA_WIDTH 16

// Destination register index width
`define REG_ADDR_WIDTH 4

// Entries held by each handshake FIFO
`define FIFO_DEPTH 4

// Fixed memory size, also the end of its address window
`define FIXED_MEM_WORDS 1024

// Flash port address width, covers the whole fixed memory
`define FLASH_ADDR_WIDTH 10

`endif
